// File: view_pkg.sv
//##################################################
// Shared widths, colours and the LFSR seed for the
// play-field view. Modules import what they need.
//##################################################

package view_pkg;

	// Screen coordinate and colour types.
	typedef logic [8:0]  x_t;	// Column, up to 512.
	typedef logic [7:0]  y_t;	// Row, up to 256.
	typedef logic [11:0] color_t;	// RGB444, zero is transparent.

	//##################################################
	// Object colours
	//##################################################
	localparam color_t COLOR_BG    = 12'h642;	// Dirt brown.
	localparam color_t COLOR_GOLD  = 12'hfd0;
	localparam color_t COLOR_STONE = 12'h888;

	// Any non-zero value works here.
	localparam logic [7:0] LFSR_SEED = 8'h5a;

endpackage

// File: lfsr.sv
//##################################################
// 8-bit Fibonacci LFSR, steps once per advance.
//##################################################
`timescale 1ns/1ns

module lfsr import view_pkg::*; (
	input  logic       clk,
	input  logic       resetn,
	input  logic       advance,
	output logic [7:0] rnd
);

	always_ff @(posedge clk) begin
		if (!resetn)
			rnd <= LFSR_SEED;
		else if (advance)
			rnd <= {rnd[6:0], rnd[7] ^ rnd[5] ^ rnd[4] ^ rnd[3]};	// Taps 8,6,5,4.
	end

	// The all-zero state would lock up.
	a_never_zero: assert property (@(posedge clk) disable iff (!resetn)
		rnd != 8'd0);

endmodule

// File: frame_tick.sv
//##################################################
// Frame-rate divider, one-cycle tick per FRAME_DIV.
//##################################################
`timescale 1ns/1ns

module frame_tick #(
	parameter int FRAME_DIV = 833333
) (
	input  logic clk,
	input  logic resetn,
	output logic tick
);

	localparam int CW = $clog2(FRAME_DIV + 1);

	logic [CW-1:0] cnt;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt  <= CW'(FRAME_DIV - 1);
			tick <= 1'b0;
		end else begin
			tick <= (cnt == '0);
			cnt  <= (cnt == '0) ? CW'(FRAME_DIV - 1) : cnt - 1'b1;	// Reload at zero.
		end
	end

endmodule

// File: object_placer.sv
//##################################################
// Maps a random byte onto the object grid. Stone
// follows rnd; gold is held from the earlier roll.
//##################################################
`timescale 1ns/1ns

module object_placer import view_pkg::*; #(
	parameter int GRID     = 20,
	parameter int Y_TOP    = 80,
	parameter int COL_BITS = 4,
	parameter int ROW_BITS = 3
) (
	input  logic       clk,
	input  logic       resetn,
	input  logic [7:0] rnd,
	input  logic       capture_gold,
	output x_t         gold_x,
	output y_t         gold_y,
	output x_t         stone_x,
	output y_t         stone_y
);

	logic [COL_BITS-1:0] col;
	logic [ROW_BITS-1:0] row;

	// Column from the low bits, row from the bits above.
	assign col = rnd[COL_BITS-1:0];
	assign row = rnd[COL_BITS +: ROW_BITS];

	assign stone_x = x_t'(col * GRID);
	assign stone_y = y_t'(Y_TOP + row * GRID);	// Keeps clear of the top margin.

	always_ff @(posedge clk) begin
		if (!resetn) begin
			gold_x <= '0;
			gold_y <= y_t'(Y_TOP);
		end else if (capture_gold) begin
			gold_x <= stone_x;
			gold_y <= stone_y;
		end
	end

endmodule

// File: rect_drawer.sv
//##################################################
// Raster engine. Emits each pixel of a filled
// rectangle, row by row, one per accepted cycle.
//##################################################
`timescale 1ns/1ns

module rect_drawer import view_pkg::*; (
	input  logic   clk,
	input  logic   resetn,
	input  logic   start,
	input  x_t     rx,
	input  y_t     ry,
	input  x_t     rw,
	input  y_t     rh,
	input  color_t rcolor,
	input  logic   d_ready,
	output x_t     d_x,
	output y_t     d_y,
	output color_t d_color,
	output logic   d_valid,
	output logic   done
);

	x_t     bx, bw, cx;
	y_t     by, bh, cy;
	color_t bc;
	logic   step;
	logic   last;

	assign step = d_valid && d_ready;
	assign last = (cx == bw - 1'b1) && (cy == bh - 1'b1);

	// Latched command and walking offsets.
	always_ff @(posedge clk) begin
		if (start && !d_valid) begin
			bx <= rx;
			by <= ry;
			bw <= rw;
			bh <= rh;
			bc <= rcolor;
			cx <= '0;
			cy <= '0;
		end else if (step) begin
			if (cx == bw - 1'b1) begin
				cx <= '0;
				cy <= cy + 1'b1;	// Next row.
			end else begin
				cx <= cx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			d_valid <= 1'b0;
			done    <= 1'b0;
		end else begin
			done <= step && last;
			if (start && !d_valid)
				d_valid <= 1'b1;
			else if (step && last)
				d_valid <= 1'b0;
		end
	end

	assign d_x     = bx + cx;
	assign d_y     = by + cy;
	assign d_color = bc;

	a_in_rect: assert property (@(posedge clk) disable iff (!resetn)
		d_valid |-> (d_x >= bx) && (x_t'(d_x - bx) < bw) &&
			(d_y >= by) && (y_t'(d_y - by) < bh));

endmodule

// File: view_sequencer.sv
//##################################################
// Frame FSM. Once armed by go, each tick rolls two
// positions and draws background, gold and stone.
//##################################################
`timescale 1ns/1ns

module view_sequencer import view_pkg::*; #(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240,
	parameter int SPRITE   = 20
) (
	input  logic   clk,
	input  logic   resetn,
	input  logic   go,
	input  logic   tick,
	input  logic   done,
	input  x_t     gold_x,
	input  y_t     gold_y,
	input  x_t     stone_x,
	input  y_t     stone_y,
	output logic   advance,
	output logic   capture_gold,
	output logic   start,
	output x_t     rx,
	output y_t     ry,
	output x_t     rw,
	output y_t     rh,
	output color_t rcolor
);

	typedef enum logic [3:0] {
		S_IDLE, S_ROLL1, S_ROLL2,
		S_BG, S_BG_WAIT, S_GOLD, S_GOLD_WAIT, S_STONE, S_STONE_WAIT
	} state_t;

	state_t state;
	logic   armed;
	logic   is_wait;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= S_IDLE;
			armed <= 1'b0;
		end else begin
			if (go)
				armed <= 1'b1;
			case (state)
				S_IDLE:       if (tick && armed) state <= S_ROLL1;	// Ticks mid-frame are lost.
				S_ROLL1:      state <= S_ROLL2;
				S_ROLL2:      state <= S_BG;
				S_BG:         state <= S_BG_WAIT;
				S_BG_WAIT:    if (done) state <= S_GOLD;
				S_GOLD:       state <= S_GOLD_WAIT;
				S_GOLD_WAIT:  if (done) state <= S_STONE;
				S_STONE:      state <= S_STONE_WAIT;
				S_STONE_WAIT: if (done) state <= S_IDLE;
				default:      state <= S_IDLE;
			endcase
		end
	end

	// Second roll lands in the LFSR as gold is captured.
	assign advance      = (state == S_ROLL1) || (state == S_ROLL2);
	assign capture_gold = (state == S_ROLL2);
	assign start        = (state == S_BG) || (state == S_GOLD) || (state == S_STONE);
	assign is_wait      = (state == S_BG_WAIT) || (state == S_GOLD_WAIT) ||
		(state == S_STONE_WAIT);

	//##################################################
	// Rectangle command per phase
	//##################################################
	always_comb begin
		rx     = '0;
		ry     = '0;
		rw     = x_t'(SCREEN_W);
		rh     = y_t'(SCREEN_H);
		rcolor = COLOR_BG;
		if (state == S_GOLD || state == S_GOLD_WAIT) begin
			rx     = gold_x;
			ry     = gold_y;
			rw     = x_t'(SPRITE);
			rh     = y_t'(SPRITE);
			rcolor = COLOR_GOLD;
		end else if (state == S_STONE || state == S_STONE_WAIT) begin
			rx     = stone_x;
			ry     = stone_y;
			rw     = x_t'(SPRITE);
			rh     = y_t'(SPRITE);
			rcolor = COLOR_STONE;
		end
	end

	// Drawer finishes only while a phase waits for it.
	a_done_in_wait: assert property (@(posedge clk) disable iff (!resetn)
		done |-> is_wait);

endmodule

// File: pixel_out.sv
//##################################################
// Output register with valid/ready. Colour zero is
// taken from the drawer but never shown.
//##################################################
`timescale 1ns/1ns

module pixel_out import view_pkg::*; (
	input  logic   clk,
	input  logic   resetn,
	input  x_t     d_x,
	input  y_t     d_y,
	input  color_t d_color,
	input  logic   d_valid,
	input  logic   pix_ready,
	output logic   d_ready,
	output x_t     pix_x,
	output y_t     pix_y,
	output color_t pix_color,
	output logic   pix_valid
);

	logic load;

	assign d_ready = !pix_valid || pix_ready;	// Empty or emptying.
	assign load    = d_valid && d_ready && (d_color != '0);

	always_ff @(posedge clk) begin
		if (load) begin
			pix_x     <= d_x;
			pix_y     <= d_y;
			pix_color <= d_color;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			pix_valid <= 1'b0;
		else if (load)
			pix_valid <= 1'b1;
		else if (pix_ready)
			pix_valid <= 1'b0;
	end

	a_hold_on_stall: assert property (@(posedge clk) disable iff (!resetn)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_x) && $stable(pix_y) &&
			$stable(pix_color));

endmodule

// File: view.sv
//##################################################
// Play-field view top. Draws one frame per tick as
// a pixel stream for the frame-buffer writer.
//##################################################
`timescale 1ns/1ns

module view import view_pkg::*; #(
	parameter int SCREEN_W  = 320,
	parameter int SCREEN_H  = 240,
	parameter int FRAME_DIV = 833333,	// 60 Hz at 50 MHz.
	parameter int GRID      = 20,
	parameter int SPRITE    = 20,
	parameter int Y_TOP     = 80,
	parameter int COL_BITS  = 4,
	parameter int ROW_BITS  = 3
) (
	input  logic   clk,
	input  logic   resetn,
	input  logic   go,
	output x_t     pix_x,
	output y_t     pix_y,
	output color_t pix_color,
	output logic   pix_valid,
	input  logic   pix_ready
);

	// Every grid cell must fit on the screen.
	if (COL_BITS + ROW_BITS > 8)
		$error("view: COL_BITS + ROW_BITS exceeds the LFSR width");
	if ((2**COL_BITS - 1) * GRID + SPRITE > SCREEN_W)
		$error("view: object columns run past SCREEN_W");
	if (Y_TOP + (2**ROW_BITS - 1) * GRID + SPRITE > SCREEN_H)
		$error("view: object rows run past SCREEN_H");

	logic       tick, advance, capture_gold, start, done, d_valid, d_ready;
	logic [7:0] rnd;
	x_t         gold_x, stone_x, rx, rw, d_x;
	y_t         gold_y, stone_y, ry, rh, d_y;
	color_t     rcolor, d_color;

	frame_tick #(.FRAME_DIV(FRAME_DIV)) i_tick (.clk, .resetn, .tick);

	lfsr i_lfsr (.clk, .resetn, .advance, .rnd);

	object_placer #(
		.GRID(GRID), .Y_TOP(Y_TOP), .COL_BITS(COL_BITS), .ROW_BITS(ROW_BITS)
	) i_placer (
		.clk, .resetn, .rnd, .capture_gold,
		.gold_x, .gold_y, .stone_x, .stone_y
	);

	view_sequencer #(
		.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H), .SPRITE(SPRITE)
	) i_seq (
		.clk, .resetn, .go, .tick, .done,
		.gold_x, .gold_y, .stone_x, .stone_y,
		.advance, .capture_gold, .start, .rx, .ry, .rw, .rh, .rcolor
	);

	rect_drawer i_drawer (
		.clk, .resetn, .start, .rx, .ry, .rw, .rh, .rcolor, .d_ready,
		.d_x, .d_y, .d_color, .d_valid, .done
	);

	pixel_out i_out (
		.clk, .resetn, .d_x, .d_y, .d_color, .d_valid, .pix_ready,
		.d_ready, .pix_x, .pix_y, .pix_color, .pix_valid
	);

endmodule

// File: view_checker.sv
//##################################################
// Testbench checker. Models every frame from the
// placement rules and compares each pixel transfer.
//##################################################
`timescale 1ns/1ns

module view_checker import view_pkg::*; #(
	parameter int SCREEN_W = 24,
	parameter int SCREEN_H = 16,
	parameter int GRID     = 4,
	parameter int SPRITE   = 3,
	parameter int Y_TOP    = 4,
	parameter int COL_BITS = 2,
	parameter int ROW_BITS = 1
) (
	input  logic        clk,
	input  logic        resetn,
	input  logic        go,
	input  logic        tick,
	input  x_t          pix_x,
	input  y_t          pix_y,
	input  color_t      pix_color,
	input  logic        pix_valid,
	input  logic        pix_ready,
	input  logic [95:0] test_name,
	output int          errors,
	output int          frames,
	output int          ticks_seen,
	output logic        in_frame
);

	logic [7:0]  r_model;
	logic        armed, stalled, owe_next;
	int          idle_ticks;	// Armed ticks since the last frame began.
	logic [29:0] exp_q [$];	// {last of rect, x, y, colour}.
	logic [28:0] held;

	function automatic logic [7:0] roll(input logic [7:0] r);
		return {r[6:0], r[7] ^ r[5] ^ r[4] ^ r[3]};
	endfunction

	function automatic int grid_x(input logic [7:0] r);
		return int'(r % (1 << COL_BITS)) * GRID;
	endfunction

	function automatic int grid_y(input logic [7:0] r);
		return Y_TOP + int'((r >> COL_BITS) % (1 << ROW_BITS)) * GRID;
	endfunction

	task automatic push_rect(input int x0, input int y0, input int w, input int h,
		input color_t c);
		for (int j = 0; j < h; j++)
			for (int i = 0; i < w; i++)
				exp_q.push_back({i == w - 1 && j == h - 1, x_t'(x0 + i), y_t'(y0 + j), c});
	endtask

	// Gold from the first roll, stone from the second.
	task automatic build_frame();
		int gx, gy;
		r_model = roll(r_model);
		gx      = grid_x(r_model);
		gy      = grid_y(r_model);
		r_model = roll(r_model);
		push_rect(0, 0, SCREEN_W, SCREEN_H, COLOR_BG);
		push_rect(gx, gy, SPRITE, SPRITE, COLOR_GOLD);
		push_rect(grid_x(r_model), grid_y(r_model), SPRITE, SPRITE, COLOR_STONE);
	endtask

	task automatic expect_val(input string what, input int exp, input int act);
		if (exp != act) begin
			errors++;
			$display("Fail %s: %s expected %0h, actual %0h", test_name, what, exp, act);
		end
	endtask

	task automatic report(input string msg);
		errors++;
		$display("Error in %s: %s.", test_name, msg);
	endtask

	always @(posedge clk) begin
		logic [29:0] px;
		if (!resetn) begin
			r_model    = LFSR_SEED;
			armed      = 1'b0;
			stalled    = 1'b0;
			owe_next   = 1'b0;
			idle_ticks = 0;
			errors     = 0;
			frames     = 0;
			ticks_seen = 0;
			in_frame   = 1'b0;
			exp_q.delete();
		end else begin
			if (tick)
				ticks_seen++;
			if (tick && armed)
				idle_ticks++;
			if (idle_ticks > 5) begin
				report("no frame started for several ticks after go");
				idle_ticks = 0;
			end
			if (pix_valid && !armed)
				report("pixel valid before go");
			if (stalled && (!pix_valid || {pix_x, pix_y, pix_color} != held))
				report("pixel changed while stalled");
			if (owe_next && !pix_valid)
				report("gap inside a rectangle");
			owe_next = 1'b0;
			if (pix_valid && pix_ready) begin
				if (exp_q.size() == 0) begin
					build_frame();
					idle_ticks = 0;
				end
				px = exp_q.pop_front();
				expect_val("x", px[28:20], pix_x);
				expect_val("y", px[19:12], pix_y);
				expect_val("colour", px[11:0], pix_color);
				owe_next = !px[29];	// Next pixel of the rectangle is due.
				if (exp_q.size() == 0)
					frames++;
			end
			stalled  = pix_valid && !pix_ready;
			held     = {pix_x, pix_y, pix_color};
			in_frame = exp_q.size() != 0;
			if (go)
				armed = 1'b1;
		end
	end

endmodule

// File: tb_view.sv
//##################################################
// Testbench top. Applies the stimulus table to the
// view with a random ready pattern per row.
//##################################################
`timescale 1ns/1ns

module tb_view import view_pkg::*; ();

	localparam int FRAME_DIV = 600;
	localparam int CLK_NS    = 100;
	localparam int ROWS      = 5;

	typedef struct packed {
		logic [95:0] name;
		logic        pulse_go;
		int          frames;	// Frame ticks to wait.
		int          duty;	// Ready percent.
	} row_t;

	logic        clk    = 1'b0;
	logic        loaded = 1'b0;
	logic        resetn, go, pix_ready, pix_valid, in_frame;
	x_t          pix_x;
	y_t          pix_y;
	color_t      pix_color;
	logic [95:0] test_name;
	int          seed, duty, total, errors, frames, ticks_seen;
	row_t        rows [ROWS];

	always #(CLK_NS / 2) clk = ~clk;

	view #(
		.SCREEN_W(24), .SCREEN_H(16), .FRAME_DIV(FRAME_DIV), .GRID(4), .SPRITE(3),
		.Y_TOP(4), .COL_BITS(2), .ROW_BITS(1)
	) i_dut (.clk, .resetn, .go, .pix_x, .pix_y, .pix_color, .pix_valid, .pix_ready);

	view_checker #(
		.SCREEN_W(24), .SCREEN_H(16), .GRID(4), .SPRITE(3),
		.Y_TOP(4), .COL_BITS(2), .ROW_BITS(1)
	) i_chk (
		.clk, .resetn, .go, .tick(i_dut.tick), .pix_x, .pix_y, .pix_color, .pix_valid,
		.pix_ready, .test_name, .errors, .frames, .ticks_seen, .in_frame
	);

	// Inputs move 1 ns after the edge.
	task automatic next_cycle();
		int draw;
		@(posedge clk);
		#1;
		draw      = int'($unsigned($random(seed)) % 100);
		pix_ready = draw < duty;
	endtask

	task automatic run_row(input row_t row);
		int target;
		test_name = row.name;
		duty      = row.duty;
		target    = ticks_seen + row.frames;
		if (row.pulse_go) begin
			go = 1'b1;
			next_cycle();
			go = 1'b0;
		end
		while (ticks_seen < target)
			next_cycle();
	endtask

	initial begin
		seed      = 45778;
		resetn    = 1'b0;
		go        = 1'b0;
		pix_ready = 1'b0;
		duty      = 100;
		test_name = "reset";
		rows[0]   = '{"idle", 1'b0, 3, 100};	// Ticks with no go.
		rows[1]   = '{"first", 1'b1, 4, 100};
		rows[2]   = '{"stall30", 1'b0, 9, 30};
		rows[3]   = '{"ready70", 1'b0, 4, 70};
		rows[4]   = '{"again", 1'b1, 4, 100};
		total     = 0;
		for (int k = 0; k < ROWS; k++)
			total += rows[k].frames;
		loaded = 1'b1;
		repeat (16) next_cycle();
		resetn = 1'b1;
		for (int k = 0; k < ROWS; k++)
			run_row(rows[k]);
		// Let the frame of the last tick start and drain.
		while (!in_frame)
			next_cycle();
		while (in_frame)
			next_cycle();
		$display("Errors: %0d, frames checked: %0d", errors, frames);
		if (errors == 0 && frames > 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		wait (loaded);
		#((total + 2) * FRAME_DIV * CLK_NS);
		$display("Watchdog: the run timed out before the tests finished.");
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: src.f
view_pkg.sv
lfsr.sv
frame_tick.sv
object_placer.sv
rect_drawer.sv
view_sequencer.sv
pixel_out.sv
view.sv
view_checker.sv
tb_view.sv

// File: run.sh
#!/bin/sh
# Builds the view testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_view -o sim_view
./obj_dir/sim_view | tee sim.log
grep -q "Result: PASSED" sim.log
